//--- cpu_top.f
+incdir+sim
common/cpu_pkg.sv
controller/program_rom.sv
controller/controller.sv
src/program_counter.sv
src/alu.sv
src/data_path.sv
src/cpu_top.sv
sim/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cpu_top.f --top-module cpu_tb -o cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpu_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- sim/cpu_tb_programs.svh
// Instruction assembler and the test programs for the CPU testbench
// Each program appends words to the image and its outputs to the expected queue

// Packs the instruction fields into one word
function automatic cpu_pkg::instr_t make_instr(
    input cpu_pkg::alu_op_t op,
    input cpu_pkg::adev_t   adev,
    input cpu_pkg::bdev_t   bdev,
    input cpu_pkg::tdev_t   target,
    input cpu_pkg::cond_t   cond,
    input logic             keep,
    input logic             direct,
    input logic [15:0]      daddr,
    input cpu_pkg::byte_t   imm
);
    cpu_pkg::instr_t w;
    w = '0;
    w[cpu_pkg::ALUOP_MSB:cpu_pkg::ALUOP_LSB] = op;
    w[cpu_pkg::ADEV_MSB:cpu_pkg::ADEV_LSB]   = adev;
    w[cpu_pkg::BDEV_MSB:cpu_pkg::BDEV_LSB]   = bdev;
    w[cpu_pkg::TDEV_MSB:cpu_pkg::TDEV_LSB]   = target;
    w[cpu_pkg::COND_MSB:cpu_pkg::COND_LSB]   = cond;
    w[cpu_pkg::KEEP_FLAGS_BIT]               = keep;
    w[cpu_pkg::AMODE_BIT]                    = direct;   // Direct RAM address
    w[cpu_pkg::DADDR_MSB:cpu_pkg::DADDR_LSB] = daddr;
    w[cpu_pkg::IMMED_MSB:cpu_pkg::IMMED_LSB] = imm;
    return w;
endfunction

// Appends one word with register addressing
task automatic put_instr(input cpu_pkg::alu_op_t op, input cpu_pkg::adev_t adev,
                         input cpu_pkg::bdev_t bdev, input cpu_pkg::tdev_t target,
                         input cpu_pkg::cond_t cond, input logic keep,
                         input cpu_pkg::byte_t imm);
    image.push_back(make_instr(op, adev, bdev, target, cond, keep, 1'b0, 16'h0000, imm));
endtask

// Immediate into a register through the B bus
task automatic load_reg(input cpu_pkg::tdev_t target, input cpu_pkg::byte_t value);
    put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED, target,
              cpu_pkg::COND_ALWAYS, 1'b0, value);
endtask

task automatic build_programs();
    cpu_pkg::byte_t a;
    cpu_pkg::byte_t b;
    cpu_pkg::byte_t v [4];
    int             loop_addr;
    int             jump_addr;
    // ALU table, code 9 stands in for the spare codes
    for (int op = 0; op <= 9; op++) begin
        a = 8'($urandom);
        b = 8'($urandom);
        load_reg(cpu_pkg::TDEV_A, a);
        load_reg(cpu_pkg::TDEV_B, b);
        put_instr(5'(op), cpu_pkg::ADEV_A, cpu_pkg::BDEV_B, cpu_pkg::TDEV_OUT,
                  cpu_pkg::COND_ALWAYS, 1'b0, 8'h00);
        expected_q.push_back(expected_alu(5'(op), a, b));
    end
    // Compare, then one guarded output per condition code with keep-flags set
    for (int pass = 0; pass < 2; pass++) begin
        a = 8'($urandom);
        b = (pass == 0) ? 8'($urandom) : a;   // Second pass has equal operands
        load_reg(cpu_pkg::TDEV_A, a);
        load_reg(cpu_pkg::TDEV_B, b);
        put_instr(cpu_pkg::ALU_SUB, cpu_pkg::ADEV_A, cpu_pkg::BDEV_B, cpu_pkg::TDEV_NONE,
                  cpu_pkg::COND_ALWAYS, 1'b0, 8'h00);
        for (int c = 0; c < 16; c++) begin
            put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED, cpu_pkg::TDEV_OUT,
                      4'(c), 1'b1, 8'(8'h40 + c));   // A vs immediate would move flags
            if (cond_holds(4'(c), a, b)) begin
                expected_q.push_back(8'(8'h40 + c));
            end
        end
    end
    // Direct stores, read back through register B
    for (int i = 0; i < 4; i++) begin
        v[i] = 8'($urandom);
        image.push_back(make_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED,
                                   cpu_pkg::TDEV_RAM, cpu_pkg::COND_ALWAYS, 1'b0, 1'b1,
                                   16'(16'h0080 + i), v[i]));
    end
    for (int i = 0; i < 4; i++) begin
        load_reg(cpu_pkg::TDEV_B, 8'(8'h80 + i));
        put_instr(cpu_pkg::ALU_A, cpu_pkg::ADEV_RAM, cpu_pkg::BDEV_B, cpu_pkg::TDEV_OUT,
                  cpu_pkg::COND_ALWAYS, 1'b0, 8'h00);
        expected_q.push_back(v[i]);
    end
    // Counting loop, 1 up to the bound
    loop_bound = 8'(2 + $urandom % 10);
    load_reg(cpu_pkg::TDEV_B, 8'h00);
    loop_addr = image.size();
    put_instr(cpu_pkg::ALU_INC_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_B, cpu_pkg::TDEV_B,
              cpu_pkg::COND_ALWAYS, 1'b0, 8'h00);
    put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_B, cpu_pkg::TDEV_OUT,
              cpu_pkg::COND_ALWAYS, 1'b0, 8'h00);
    put_instr(cpu_pkg::ALU_SUB, cpu_pkg::ADEV_B, cpu_pkg::BDEV_IMMED, cpu_pkg::TDEV_NONE,
              cpu_pkg::COND_ALWAYS, 1'b0, loop_bound);
    put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED, cpu_pkg::TDEV_PC,
              cpu_pkg::COND_NE, 1'b1, 8'(loop_addr));
    for (int n = 1; n <= int'(loop_bound); n++) begin
        expected_q.push_back(8'(n));
    end
    // Unconditional jump over two outputs
    jump_addr = image.size();
    put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED, cpu_pkg::TDEV_PC,
              cpu_pkg::COND_ALWAYS, 1'b0, 8'(jump_addr + 3));
    load_out_imm(8'hee);   // Skipped
    load_out_imm(8'hef);   // Skipped
    load_out_imm(8'h5a);
    expected_q.push_back(8'h5a);
    // Halt loop, jumps to itself
    halt_addr = image.size();
    put_instr(cpu_pkg::ALU_B, cpu_pkg::ADEV_A, cpu_pkg::BDEV_IMMED, cpu_pkg::TDEV_PC,
              cpu_pkg::COND_ALWAYS, 1'b0, 8'(halt_addr));
endtask

// Immediate straight to the output port
task automatic load_out_imm(input cpu_pkg::byte_t value);
    load_reg(cpu_pkg::TDEV_OUT, value);
endtask

//--- sim/cpu_tb.sv
// Testbench for the microcoded 8-bit CPU
// Clock, reset, program load, output checks, watchdog and closing report
`timescale 1ns/1ps

module cpu_tb;

    localparam int          PC_WIDTH       = 8;
    localparam int          RAM_ADDR_WIDTH = 8;
    localparam int          RESET_CYCLES   = 8;
    localparam logic [31:0] SEED           = 32'ha062_9bbb;

    logic                clk;
    logic                reset;
    logic                prog_we;
    logic [PC_WIDTH-1:0] prog_addr;
    cpu_pkg::instr_t     prog_data;
    logic                out_valid;
    cpu_pkg::byte_t      out_data;
    logic [PC_WIDTH-1:0] pc;

    cpu_pkg::instr_t image [$];        // Program image, word 0 first
    cpu_pkg::byte_t  expected_q [$];   // Outputs in order of appearance
    cpu_pkg::byte_t  expected_val;
    cpu_pkg::byte_t  loop_bound;
    int              halt_addr;
    int              watchdog_cycles;
    logic            programs_ready    = 1'b0;
    int              reset_edges       = 0;
    int              mismatch_errors   = 0;
    int              unexpected_errors = 0;
    int              reset_errors      = 0;
    int              missing_outputs   = 0;

    // Reference result from the ALU operation table
    function automatic cpu_pkg::byte_t expected_alu(input cpu_pkg::alu_op_t op,
                                                    input cpu_pkg::byte_t a,
                                                    input cpu_pkg::byte_t b);
        cpu_pkg::byte_t r;
        case (op)
            5'd1:    r = a;
            5'd2:    r = b;
            5'd3:    r = a + b;       // Wraps in 8 bits
            5'd4:    r = a - b;
            5'd5:    r = a & b;
            5'd6:    r = a | b;
            5'd7:    r = a ^ b;
            5'd8:    r = b + 8'd1;
            default: r = 8'h00;       // Zero and the spare codes
        endcase
        return r;
    endfunction

    // Whether a condition holds after x minus y set the flags
    function automatic logic cond_holds(input cpu_pkg::cond_t c, input cpu_pkg::byte_t x,
                                        input cpu_pkg::byte_t y);
        cpu_pkg::byte_t diff;
        int             sdiff;
        logic           holds;
        diff  = x - y;
        sdiff = int'($signed(x)) - int'($signed(y));
        case (c)
            4'd0:    holds = 1'b1;
            4'd1:    holds = x < y;                          // Borrow
            4'd2:    holds = diff == 8'h00;
            4'd3:    holds = diff[7];
            4'd4:    holds = (sdiff > 127) || (sdiff < -128);  // Signed range left
            4'd5:    holds = x == y;
            4'd6:    holds = x != y;
            4'd7:    holds = x < y;
            4'd8:    holds = x > y;
            default: holds = 1'b0;
        endcase
        return holds;
    endfunction

    `include "cpu_tb_programs.svh"

    cpu_top #(
        .PC_WIDTH       (PC_WIDTH),
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    always @(posedge clk) begin
        if (reset) begin
            reset_edges <= reset_edges + 1;   // Synchronous reset seen
        end
    end

    // Checks at the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (reset && reset_edges > 0) begin
            assert (out_valid == 1'b0 && pc == '0) else begin
                reset_errors++;
                $display("CHECK FAILED at %0t: in reset out_valid %b pc %0d",
                         $time, out_valid, pc);
            end
        end
        if (!reset && out_valid) begin
            assert (expected_q.size() > 0) else begin
                unexpected_errors++;
                $display("Output strobe at %0t with data %h when no output was expected",
                         $time, out_data);
            end
            if (expected_q.size() > 0) begin
                expected_val = expected_q.pop_front();
                assert (out_data == expected_val) else begin
                    mismatch_errors++;
                    $display("CHECK FAILED at %0t: out_data %h, expected %h",
                             $time, out_data, expected_val);
                end
            end
        end
    end

    initial begin
        wait (programs_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the program never reached its halt loop",
                 watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_programs();
        // Load plus straight-line run, the loop body, reset and margin
        watchdog_cycles = 2 * image.size() + 4 * int'(loop_bound) + RESET_CYCLES + 50;
        programs_ready  = 1'b1;
        foreach (image[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= PC_WIDTH'(i);
            prog_data <= image[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;
        do begin
            @(negedge clk);
        end while (pc != PC_WIDTH'(halt_addr));
        repeat (2) @(negedge clk);   // Last strobe gets checked
        if (expected_q.size() != 0) begin
            missing_outputs = expected_q.size();
            $display("Program finished with %0d expected outputs never seen", missing_outputs);
        end
        $display("Errors: mismatch %0d, unexpected %0d, reset %0d, missing %0d",
                 mismatch_errors, unexpected_errors, reset_errors, missing_outputs);
        if (mismatch_errors + unexpected_errors + reset_errors + missing_outputs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src/cpu_top.sv
// Top level of the microcoded 8-bit CPU
// Program memory, controller, program counter, ALU and data path
`timescale 1ns/1ps

module cpu_top #(
    parameter int PC_WIDTH       = 8,
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                prog_we,
    input  logic [PC_WIDTH-1:0] prog_addr,
    input  cpu_pkg::instr_t     prog_data,
    output logic                out_valid,
    output cpu_pkg::byte_t      out_data,
    output logic [PC_WIDTH-1:0] pc
);

    cpu_pkg::instr_t           instruction;
    cpu_pkg::alu_op_t          alu_op;
    cpu_pkg::adev_t            adev;
    cpu_pkg::bdev_t            bdev;
    cpu_pkg::byte_t            immed;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                      we_a;
    logic                      we_b;
    logic                      we_ram;
    logic                      load_pc;
    logic                      emit_out;
    logic                      update_flags;
    cpu_pkg::byte_t            a_bus;
    cpu_pkg::byte_t            b_bus;
    cpu_pkg::byte_t            reg_b;
    cpu_pkg::byte_t            alu_result;
    cpu_pkg::flags_t           alu_flags;
    cpu_pkg::flags_t           flags;

    program_rom #(.PC_WIDTH(PC_WIDTH)) u_program_rom (
        .clk         (clk),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .pc          (pc),
        .instruction (instruction)
    );

    controller #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_controller (
        .instruction  (instruction),
        .flags        (flags),
        .reg_b        (reg_b),
        .reset        (reset),
        .alu_op       (alu_op),
        .adev         (adev),
        .bdev         (bdev),
        .immed        (immed),
        .ram_addr     (ram_addr),
        .we_a         (we_a),
        .we_b         (we_b),
        .we_ram       (we_ram),
        .load_pc      (load_pc),
        .emit_out     (emit_out),
        .update_flags (update_flags)
    );

    program_counter #(.PC_WIDTH(PC_WIDTH)) u_program_counter (
        .clk        (clk),
        .reset      (reset),
        .load_pc    (load_pc),
        .alu_result (alu_result),
        .pc         (pc)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .a_bus      (a_bus),
        .b_bus      (b_bus),
        .alu_result (alu_result),
        .alu_flags  (alu_flags)
    );

    data_path #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_data_path (
        .clk          (clk),
        .reset        (reset),
        .adev         (adev),
        .bdev         (bdev),
        .immed        (immed),
        .ram_addr     (ram_addr),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .we_a         (we_a),
        .we_b         (we_b),
        .we_ram       (we_ram),
        .update_flags (update_flags),
        .emit_out     (emit_out),
        .a_bus        (a_bus),
        .b_bus        (b_bus),
        .reg_b        (reg_b),
        .flags        (flags),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

//--- src/data_path.sv
// Register file, RAM, flag register and bus source multiplexers
// Also holds the registered output port strobe and data
`timescale 1ns/1ps

module data_path #(
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  cpu_pkg::adev_t            adev,
    input  cpu_pkg::bdev_t            bdev,
    input  cpu_pkg::byte_t            immed,
    input  logic [RAM_ADDR_WIDTH-1:0] ram_addr,
    input  cpu_pkg::byte_t            alu_result,
    input  cpu_pkg::flags_t           alu_flags,
    input  logic                      we_a,
    input  logic                      we_b,
    input  logic                      we_ram,
    input  logic                      update_flags,
    input  logic                      emit_out,
    output cpu_pkg::byte_t            a_bus,
    output cpu_pkg::byte_t            b_bus,
    output cpu_pkg::byte_t            reg_b,
    output cpu_pkg::flags_t           flags,
    output logic                      out_valid,
    output cpu_pkg::byte_t            out_data
);

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_WIDTH;

    cpu_pkg::byte_t reg_a;
    cpu_pkg::byte_t ram [RAM_DEPTH];
    cpu_pkg::byte_t ram_rdata;

    assign ram_rdata = ram[ram_addr];  // Asynchronous read

    // A bus source
    always_comb begin
        case (adev)
            cpu_pkg::ADEV_A:   a_bus = reg_a;
            cpu_pkg::ADEV_B:   a_bus = reg_b;
            cpu_pkg::ADEV_RAM: a_bus = ram_rdata;
            default:           a_bus = '0;  // Unused devices read zero
        endcase
    end

    // B bus source
    always_comb begin
        case (bdev)
            cpu_pkg::BDEV_A:     b_bus = reg_a;
            cpu_pkg::BDEV_B:     b_bus = reg_b;
            cpu_pkg::BDEV_RAM:   b_bus = ram_rdata;
            cpu_pkg::BDEV_IMMED: b_bus = immed;
            default:             b_bus = '0;
        endcase
    end

    // Registers, flags and strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a     <= '0;
            reg_b     <= '0;
            flags     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (we_a) begin
                reg_a <= alu_result;
            end
            if (we_b) begin
                reg_b <= alu_result;
            end
            if (update_flags) begin
                flags <= alu_flags;  // Seen by the next instruction
            end
            out_valid <= emit_out;   // One cycle per output instruction
        end
    end

    // RAM write and output byte
    always_ff @(posedge clk) begin
        if (we_ram) begin
            ram[ram_addr] <= alu_result;
        end
        if (emit_out) begin
            out_data <= alu_result;  // Held until the next emit
        end
    end

endmodule

//--- src/alu.sv
// 8-bit ALU
// Result with carry, zero, negative and overflow, plus unsigned compare flags
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::byte_t   a_bus,
    input  cpu_pkg::byte_t   b_bus,
    output cpu_pkg::byte_t   alu_result,
    output cpu_pkg::flags_t  alu_flags
);

    logic [8:0] sum9;
    logic [8:0] diff9;
    logic [8:0] inc9;
    logic       carry;
    logic       overflow;

    assign sum9  = {1'b0, a_bus} + {1'b0, b_bus};
    assign diff9 = {1'b0, a_bus} - {1'b0, b_bus};  // Bit 8 is the borrow
    assign inc9  = {1'b0, b_bus} + 9'd1;

    always_comb begin
        alu_result = '0;
        carry      = 1'b0;
        overflow   = 1'b0;
        case (alu_op)
            cpu_pkg::ALU_ZERO: alu_result = '0;
            cpu_pkg::ALU_A:    alu_result = a_bus;
            cpu_pkg::ALU_B:    alu_result = b_bus;
            cpu_pkg::ALU_ADD: begin
                alu_result = sum9[7:0];
                carry      = sum9[8];
                overflow   = (a_bus[7] == b_bus[7]) && (sum9[7] != a_bus[7]);  // Like signs
            end
            cpu_pkg::ALU_SUB: begin
                alu_result = diff9[7:0];
                carry      = diff9[8];
                overflow   = (a_bus[7] != b_bus[7]) && (diff9[7] != a_bus[7]);
            end
            cpu_pkg::ALU_AND:  alu_result = a_bus & b_bus;
            cpu_pkg::ALU_OR:   alu_result = a_bus | b_bus;
            cpu_pkg::ALU_XOR:  alu_result = a_bus ^ b_bus;
            cpu_pkg::ALU_INC_B: begin
                alu_result = inc9[7:0];
                carry      = inc9[8];
                overflow   = ~b_bus[7] & inc9[7];  // 0x7f to 0x80
            end
            default:           alu_result = '0;
        endcase
    end

    // Compare bits ignore the operation
    always_comb begin
        alu_flags                   = '0;
        alu_flags[cpu_pkg::FLAG_C]  = carry;
        alu_flags[cpu_pkg::FLAG_Z]  = (alu_result == 8'd0);
        alu_flags[cpu_pkg::FLAG_N]  = alu_result[7];
        alu_flags[cpu_pkg::FLAG_O]  = overflow;
        alu_flags[cpu_pkg::FLAG_EQ] = (a_bus == b_bus);
        alu_flags[cpu_pkg::FLAG_NE] = (a_bus != b_bus);
        alu_flags[cpu_pkg::FLAG_LT] = (a_bus < b_bus);   // Unsigned
        alu_flags[cpu_pkg::FLAG_GT] = (a_bus > b_bus);
    end

endmodule

//--- src/program_counter.sv
// Program counter register
// Steps by one each cycle or loads the ALU result on a jump
`timescale 1ns/1ps

module program_counter #(
    parameter int PC_WIDTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_pc,      // Jump taken this cycle
    input  cpu_pkg::byte_t      alu_result,   // Jump target
    output logic [PC_WIDTH-1:0] pc
);

    logic [PC_WIDTH-1:0] jump_target;
    logic [PC_WIDTH-1:0] pc_next;

    // Byte target sized to the counter
    assign jump_target = PC_WIDTH'(alu_result);

    always_comb begin
        if (load_pc) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc + PC_WIDTH'(1);  // Wraps at the top of program memory
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;  // Fetch starts at word 0
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- controller/controller.sv
// Horizontal instruction decoder
// Field split, 16-way condition select, gated target enables and RAM addressing
`timescale 1ns/1ps

module controller #(
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  cpu_pkg::instr_t           instruction,
    input  cpu_pkg::flags_t           flags,      // Flags from earlier instructions
    input  cpu_pkg::byte_t            reg_b,      // Register address source
    input  logic                      reset,
    output cpu_pkg::alu_op_t          alu_op,
    output cpu_pkg::adev_t            adev,
    output cpu_pkg::bdev_t            bdev,
    output cpu_pkg::byte_t            immed,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr,
    output logic                      we_a,
    output logic                      we_b,
    output logic                      we_ram,
    output logic                      load_pc,
    output logic                      emit_out,
    output logic                      update_flags
);

    logic [15:0]    direct_addr;
    logic           amode_direct;
    logic           keep_flags;
    cpu_pkg::cond_t condition;
    cpu_pkg::tdev_t target;
    logic           cond_true;
    logic           do_exec;
    logic [4:0]     tsel;         // a, b, ram, pc, out

    // Instruction decompose
    assign immed        = instruction[cpu_pkg::IMMED_MSB:cpu_pkg::IMMED_LSB];
    assign direct_addr  = instruction[cpu_pkg::DADDR_MSB:cpu_pkg::DADDR_LSB];
    assign amode_direct = instruction[cpu_pkg::AMODE_BIT];
    assign keep_flags   = instruction[cpu_pkg::KEEP_FLAGS_BIT];
    assign condition    = instruction[cpu_pkg::COND_MSB:cpu_pkg::COND_LSB];
    assign bdev         = instruction[cpu_pkg::BDEV_MSB:cpu_pkg::BDEV_LSB];
    assign adev         = instruction[cpu_pkg::ADEV_MSB:cpu_pkg::ADEV_LSB];
    assign target       = instruction[cpu_pkg::TDEV_MSB:cpu_pkg::TDEV_LSB];
    assign alu_op       = instruction[cpu_pkg::ALUOP_MSB:cpu_pkg::ALUOP_LSB];

    // Condition multiplexer over the stored flags
    always_comb begin
        case (condition)
            cpu_pkg::COND_ALWAYS: cond_true = 1'b1;
            cpu_pkg::COND_CARRY:  cond_true = flags[cpu_pkg::FLAG_C];
            cpu_pkg::COND_ZERO:   cond_true = flags[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NEG:    cond_true = flags[cpu_pkg::FLAG_N];
            cpu_pkg::COND_OVF:    cond_true = flags[cpu_pkg::FLAG_O];
            cpu_pkg::COND_EQ:     cond_true = flags[cpu_pkg::FLAG_EQ];
            cpu_pkg::COND_NE:     cond_true = flags[cpu_pkg::FLAG_NE];
            cpu_pkg::COND_LT:     cond_true = flags[cpu_pkg::FLAG_LT];
            cpu_pkg::COND_GT:     cond_true = flags[cpu_pkg::FLAG_GT];
            default:              cond_true = 1'b0;  // Codes 9..15 never run
        endcase
    end

    // Nothing executes while reset is held
    assign do_exec = cond_true & ~reset;

    // Target decode to one-hot
    always_comb begin
        tsel = '0;
        case (target)
            cpu_pkg::TDEV_NONE: tsel = 5'b00000;
            cpu_pkg::TDEV_A:    tsel = 5'b00001;
            cpu_pkg::TDEV_B:    tsel = 5'b00010;
            cpu_pkg::TDEV_RAM:  tsel = 5'b00100;
            cpu_pkg::TDEV_PC:   tsel = 5'b01000;  // Jump
            cpu_pkg::TDEV_OUT:  tsel = 5'b10000;
            default:            tsel = 5'b00000;  // Spare targets are no-ops
        endcase
    end

    assign we_a     = do_exec & tsel[0];
    assign we_b     = do_exec & tsel[1];
    assign we_ram   = do_exec & tsel[2];
    assign load_pc  = do_exec & tsel[3];
    assign emit_out = do_exec & tsel[4];

    // Flags only move on an executed instruction without keep-flags
    assign update_flags = do_exec & ~keep_flags;

    // Direct address is cut down to the RAM size
    assign ram_addr = amode_direct ? RAM_ADDR_WIDTH'(direct_addr)
                                   : RAM_ADDR_WIDTH'(reg_b);

endmodule

//--- controller/program_rom.sv
// Program memory holding the microcode words
// Loaded through a write strobe, read combinationally at the PC
`timescale 1ns/1ps

module program_rom #(
    parameter int PC_WIDTH = 8
) (
    input  logic                clk,
    input  logic                prog_we,      // Load strobe, only used under reset
    input  logic [PC_WIDTH-1:0] prog_addr,
    input  cpu_pkg::instr_t     prog_data,
    input  logic [PC_WIDTH-1:0] pc,
    output cpu_pkg::instr_t     instruction
);

    localparam int DEPTH = 2 ** PC_WIDTH;

    cpu_pkg::instr_t mem [DEPTH];  // Full address space of the PC

    // Unloaded words start as zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;  // One word per strobe
        end
    end

    // Zero latency fetch, the instruction executes in the same cycle
    assign instruction = mem[pc];

endmodule

//--- common/cpu_pkg.sv
// Shared definitions for the microcoded 8-bit CPU
// Instruction field positions, vector types, ALU, device and condition codes
package cpu_pkg;

    typedef logic [47:0] instr_t;    // One horizontal instruction word
    typedef logic [7:0]  byte_t;     // Data on any bus
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  adev_t;
    typedef logic [2:0]  bdev_t;
    typedef logic [3:0]  tdev_t;
    typedef logic [3:0]  cond_t;
    typedef logic [7:0]  flags_t;    // c z n o eq ne lt gt, carry in bit 0

    // Field positions inside instr_t
    localparam int IMMED_LSB      = 0;
    localparam int IMMED_MSB      = 7;
    localparam int DADDR_LSB      = 8;
    localparam int DADDR_MSB      = 23;
    localparam int AMODE_BIT      = 24;   // 1 = direct, 0 = via register B
    localparam int KEEP_FLAGS_BIT = 28;   // 1 = leave flags alone
    localparam int COND_LSB       = 29;
    localparam int COND_MSB       = 32;
    localparam int BDEV_LSB       = 33;
    localparam int BDEV_MSB       = 35;
    localparam int ADEV_LSB       = 36;
    localparam int ADEV_MSB       = 38;
    localparam int TDEV_LSB       = 39;
    localparam int TDEV_MSB       = 42;
    localparam int ALUOP_LSB      = 43;
    localparam int ALUOP_MSB      = 47;

    // Flag bit positions in flags_t
    localparam int FLAG_C  = 0;
    localparam int FLAG_Z  = 1;
    localparam int FLAG_N  = 2;
    localparam int FLAG_O  = 3;
    localparam int FLAG_EQ = 4;
    localparam int FLAG_NE = 5;
    localparam int FLAG_LT = 6;
    localparam int FLAG_GT = 7;

    // ALU operations, unlisted codes give zero
    localparam alu_op_t ALU_ZERO  = 5'd0;
    localparam alu_op_t ALU_A     = 5'd1;
    localparam alu_op_t ALU_B     = 5'd2;
    localparam alu_op_t ALU_ADD   = 5'd3;
    localparam alu_op_t ALU_SUB   = 5'd4;
    localparam alu_op_t ALU_AND   = 5'd5;
    localparam alu_op_t ALU_OR    = 5'd6;
    localparam alu_op_t ALU_XOR   = 5'd7;
    localparam alu_op_t ALU_INC_B = 5'd8;

    // Bus sources
    localparam adev_t ADEV_A     = 3'd0;
    localparam adev_t ADEV_B     = 3'd1;
    localparam adev_t ADEV_RAM   = 3'd2;
    localparam bdev_t BDEV_A     = 3'd0;
    localparam bdev_t BDEV_B     = 3'd1;
    localparam bdev_t BDEV_RAM   = 3'd2;
    localparam bdev_t BDEV_IMMED = 3'd3;

    // Targets, unlisted codes write nothing
    localparam tdev_t TDEV_NONE = 4'd0;
    localparam tdev_t TDEV_A    = 4'd1;
    localparam tdev_t TDEV_B    = 4'd2;
    localparam tdev_t TDEV_RAM  = 4'd3;
    localparam tdev_t TDEV_PC   = 4'd4;
    localparam tdev_t TDEV_OUT  = 4'd5;

    // Conditions, 9 to 15 never hold
    localparam cond_t COND_ALWAYS = 4'd0;
    localparam cond_t COND_CARRY  = 4'd1;
    localparam cond_t COND_ZERO   = 4'd2;
    localparam cond_t COND_NEG    = 4'd3;
    localparam cond_t COND_OVF    = 4'd4;
    localparam cond_t COND_EQ     = 4'd5;
    localparam cond_t COND_NE     = 4'd6;
    localparam cond_t COND_LT     = 4'd7;
    localparam cond_t COND_GT     = 4'd8;

endpackage
